//--- rtl/frog_consts.svh
`ifndef FROG_CONSTS_SVH
`define FROG_CONSTS_SVH

// Screen and bus widths.
`define SCREEN_W     320
`define SCREEN_H     240
`define COORD_W      9
`define ADDR_W       17
`define COLOR_W      3

// Water band between the two grass banks.
`define RIVER_TOP    40
`define RIVER_BOTTOM 200

// River objects.
`define OBJ_W        96
`define OBJ_H        40
`define OBJ1_X       20
`define OBJ1_Y       80
`define OBJ2_X       120
`define OBJ2_Y       150

// Digit cells in the top right corner.
`define DIGIT_W      7
`define DIGIT_H      10
`define SCORE_X      300
`define SCORE_Y      14
`define LIVES_X      300
`define LIVES_Y      27

// Frog sprite and its furthest legal origin.
`define FROG_W       32
`define FROG_H       24
`define FROG_MAX_X   288
`define FROG_MAX_Y   216

// Colours, packed as red, green, blue.
`define C_BLACK      0
`define C_WATER      1
`define C_GRASS      2
`define C_FROG       3
`define C_LOG        6
`define C_INK        7

`endif

//--- rtl/frog_pkg.sv
package frog_pkg;

    // Frame sequencer states.
    typedef enum logic [1:0] {
        S_IDLE  = 2'd0,
        S_JOB   = 2'd1,
        S_NEXT  = 2'd2,
        S_DRAIN = 2'd3
    } ctrl_state_t;

    // Draw jobs, listed in the order a frame runs them.
    typedef enum logic [2:0] {
        JOB_BG      = 3'd0,
        JOB_SCORE   = 3'd1,
        JOB_LIVES   = 3'd2,
        JOB_RIVER_1 = 3'd3,
        JOB_RIVER_2 = 3'd4,
        JOB_FROG    = 3'd5
    } draw_job_t;

endpackage

//--- rtl/draw_control.sv
module draw_control (
    input  logic               clk,
    input  logic               reset,
    input  logic               go,
    input  logic               job_done,
    input  logic               shader_empty,
    input  logic               writer_empty,
    output frog_pkg::draw_job_t job,
    output logic               job_start,
    output logic               busy
);

    import frog_pkg::*;

    ctrl_state_t state;

    // Frame sequencer.
    // Each job is started with a one-cycle job_start and ends on job_done.
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= S_IDLE;
            job       <= JOB_BG;
            job_start <= 1'b0;
        end else begin
            job_start <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (go) begin
                        state     <= S_JOB;
                        job       <= JOB_BG;
                        job_start <= 1'b1;
                    end
                end
                S_JOB: begin
                    if (job_done) begin
                        state <= S_NEXT;
                    end
                end
                S_NEXT: begin
                    // Frog is always last so it lands on top of the logs.
                    if (job == JOB_FROG) begin
                        state <= S_DRAIN;
                    end else begin
                        state     <= S_JOB;
                        job       <= draw_job_t'(job + 3'd1);
                        job_start <= 1'b1;
                    end
                end
                S_DRAIN: begin
                    // Wait for the final pixel to be acked on the bus.
                    if (shader_empty && writer_empty) begin
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    assign busy = (state != S_IDLE);

endmodule

//--- rtl/raster_scanner.sv
`include "frog_consts.svh"

module raster_scanner (
    input  logic                clk,
    input  logic                reset,
    input  frog_pkg::draw_job_t job,
    input  logic                job_start,
    input  logic                loc_ready,
    output logic                loc_valid,
    output logic [`COORD_W-1:0] loc_x,
    output logic [`COORD_W-1:0] loc_y,
    output logic                job_done
);

    import frog_pkg::*;

    logic [`COORD_W-1:0] max_x;
    logic [`COORD_W-1:0] max_y;
    logic                last_x;
    logic                last_y;
    logic                advance;

    // Last local column and row of the current job's rectangle.
    always_comb begin
        case (job)
            JOB_SCORE, JOB_LIVES: begin
                max_x = `COORD_W'(`DIGIT_W - 1);
                max_y = `COORD_W'(`DIGIT_H - 1);
            end
            JOB_RIVER_1, JOB_RIVER_2: begin
                max_x = `COORD_W'(`OBJ_W - 1);
                max_y = `COORD_W'(`OBJ_H - 1);
            end
            JOB_FROG: begin
                max_x = `COORD_W'(`FROG_W - 1);
                max_y = `COORD_W'(`FROG_H - 1);
            end
            default: begin
                max_x = `COORD_W'(`SCREEN_W - 1);
                max_y = `COORD_W'(`SCREEN_H - 1);
            end
        endcase
    end

    assign last_x  = (loc_x == max_x);
    assign last_y  = (loc_y == max_y);
    assign advance = loc_valid && loc_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            loc_valid <= 1'b0;
            job_done  <= 1'b0;
        end else begin
            job_done <= 1'b0;
            if (job_start) begin
                loc_valid <= 1'b1;
            end else if (advance && last_x && last_y) begin
                loc_valid <= 1'b0;
                job_done  <= 1'b1;
            end
        end
    end

    // Row by row, x fastest.
    always_ff @(posedge clk) begin
        if (job_start) begin
            loc_x <= '0;
            loc_y <= '0;
        end else if (advance) begin
            if (last_x) begin
                loc_x <= '0;
                loc_y <= loc_y + 1'b1;
            end else begin
                loc_x <= loc_x + 1'b1;
            end
        end
    end

endmodule

//--- rtl/pixel_shader.sv
`include "frog_consts.svh"

module pixel_shader (
    input  logic                clk,
    input  logic                reset,
    input  frog_pkg::draw_job_t job,
    input  logic                loc_valid,
    input  logic [`COORD_W-1:0] loc_x,
    input  logic [`COORD_W-1:0] loc_y,
    input  logic [3:0]          score,
    input  logic [3:0]          lives,
    input  logic [`COORD_W-1:0] frog_x,
    input  logic [`COORD_W-1:0] frog_y,
    input  logic                pix_ready,
    output logic                loc_ready,
    output logic                pix_valid,
    output logic [`COORD_W-1:0] pix_x,
    output logic [`COORD_W-1:0] pix_y,
    output logic [`COLOR_W-1:0] pix_color,
    output logic                shader_empty
);

    import frog_pkg::*;

    logic [`COORD_W-1:0] org_x;
    logic [`COORD_W-1:0] org_y;
    logic [`COORD_W-1:0] frog_cx;
    logic [`COORD_W-1:0] frog_cy;
    logic [`COLOR_W-1:0] color;
    logic [`COLOR_W-1:0] digit_color;
    logic [3:0]          digit;
    logic [2:0]          font_col;
    logic [2:0]          font_line;
    logic [34:0]         glyph_bits;
    logic [34:0]         row_bits;
    logic [4:0]          col_bits;
    logic                in_font;

    // 5x7 digit glyphs, top row in the high bits, leftmost pixel first.
    function automatic logic [34:0] glyph(input logic [3:0] value);
        case (value)
            4'd0:    glyph = 35'b01110_10001_10011_10101_11001_10001_01110;
            4'd1:    glyph = 35'b00100_01100_00100_00100_00100_00100_01110;
            4'd2:    glyph = 35'b01110_10001_00001_00010_00100_01000_11111;
            4'd3:    glyph = 35'b11111_00010_00100_00010_00001_10001_01110;
            4'd4:    glyph = 35'b00010_00110_01010_10010_11111_00010_00010;
            4'd5:    glyph = 35'b11111_10000_11110_00001_00001_10001_01110;
            4'd6:    glyph = 35'b00110_01000_10000_11110_10001_10001_01110;
            4'd7:    glyph = 35'b11111_00001_00010_00100_01000_01000_01000;
            4'd8:    glyph = 35'b01110_10001_10001_01110_10001_10001_01110;
            4'd9:    glyph = 35'b01110_10001_10001_01111_00001_00010_01100;
            default: glyph = '0;
        endcase
    endfunction

    // Keep the whole frog on screen.
    assign frog_cx = (frog_x > `COORD_W'(`FROG_MAX_X)) ? `COORD_W'(`FROG_MAX_X) : frog_x;
    assign frog_cy = (frog_y > `COORD_W'(`FROG_MAX_Y)) ? `COORD_W'(`FROG_MAX_Y) : frog_y;

    // Glyph sits one pixel in from the cell's top left corner.
    assign digit      = (job == JOB_LIVES) ? lives : score;
    assign in_font    = (loc_x >= `COORD_W'(1)) && (loc_x <= `COORD_W'(5)) &&
                        (loc_y >= `COORD_W'(1)) && (loc_y <= `COORD_W'(7));
    assign font_col   = loc_x[2:0] - 3'd1;
    assign font_line  = loc_y[2:0] - 3'd1;
    assign glyph_bits = glyph(digit);
    assign row_bits   = glyph_bits << (font_line * 5);
    assign col_bits   = row_bits[34:30] << font_col;
    assign digit_color = (in_font && col_bits[4]) ? `COLOR_W'(`C_INK) : `COLOR_W'(`C_BLACK);

    always_comb begin
        org_x = '0;
        org_y = '0;
        color = `COLOR_W'(`C_BLACK);
        case (job)
            JOB_BG: begin
                if (loc_y >= `COORD_W'(`RIVER_TOP) && loc_y < `COORD_W'(`RIVER_BOTTOM)) begin
                    color = `COLOR_W'(`C_WATER);
                end else begin
                    color = `COLOR_W'(`C_GRASS);
                end
            end
            JOB_SCORE: begin
                org_x = `COORD_W'(`SCORE_X);
                org_y = `COORD_W'(`SCORE_Y);
                color = digit_color;
            end
            JOB_LIVES: begin
                org_x = `COORD_W'(`LIVES_X);
                org_y = `COORD_W'(`LIVES_Y);
                color = digit_color;
            end
            JOB_RIVER_1: begin
                org_x = `COORD_W'(`OBJ1_X);
                org_y = `COORD_W'(`OBJ1_Y);
                color = `COLOR_W'(`C_LOG);
            end
            JOB_RIVER_2: begin
                org_x = `COORD_W'(`OBJ2_X);
                org_y = `COORD_W'(`OBJ2_Y);
                color = `COLOR_W'(`C_LOG);
            end
            JOB_FROG: begin
                org_x = frog_cx;
                org_y = frog_cy;
                color = `COLOR_W'(`C_FROG);
            end
            default: begin
                color = `COLOR_W'(`C_BLACK);
            end
        endcase
    end

    // Register is free when empty or being drained this cycle.
    assign loc_ready    = !pix_valid || pix_ready;
    assign shader_empty = !pix_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            pix_valid <= 1'b0;
        end else if (loc_ready) begin
            pix_valid <= loc_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (loc_valid && loc_ready) begin
            pix_x     <= org_x + loc_x;
            pix_y     <= org_y + loc_y;
            pix_color <= color;
        end
    end

endmodule

//--- rtl/wb_pixel_writer.sv
`include "frog_consts.svh"

module wb_pixel_writer (
    input  logic                clk,
    input  logic                reset,
    input  logic                pix_valid,
    input  logic [`COORD_W-1:0] pix_x,
    input  logic [`COORD_W-1:0] pix_y,
    input  logic [`COLOR_W-1:0] pix_color,
    input  logic                wb_ack,
    output logic                pix_ready,
    output logic                writer_empty,
    output logic                wb_cyc,
    output logic                wb_stb,
    output logic                wb_we,
    output logic [`ADDR_W-1:0]  wb_adr,
    output logic [`COLOR_W-1:0] wb_dat
);

    // High while a pixel is held and its write is on the bus.
    logic pending;

    // Take a new pixel when idle or on the ack of the one held.
    assign pix_ready    = !pending || wb_ack;
    assign writer_empty = !pending;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
        end else if (pix_ready) begin
            pending <= pix_valid;
        end
    end

    // Linear frame buffer, one word per pixel.
    always_ff @(posedge clk) begin
        if (pix_valid && pix_ready) begin
            wb_adr <= `ADDR_W'(pix_y * `SCREEN_W + pix_x);
            wb_dat <= pix_color;
        end
    end

    // Single write cycle per pixel.
    assign wb_cyc = pending;
    assign wb_stb = pending;
    assign wb_we  = pending;

endmodule

//--- rtl/frog_draw_top.sv
`include "frog_consts.svh"

module frog_draw_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                go,
    input  logic [3:0]          score,
    input  logic [3:0]          lives,
    input  logic [`COORD_W-1:0] frog_x,
    input  logic [`COORD_W-1:0] frog_y,
    output logic                busy,
    output logic                wb_cyc,
    output logic                wb_stb,
    output logic                wb_we,
    output logic [`ADDR_W-1:0]  wb_adr,
    output logic [`COLOR_W-1:0] wb_dat,
    input  logic                wb_ack
);

    import frog_pkg::*;

    draw_job_t           job;
    logic                job_start;
    logic                job_done;
    logic                loc_valid;
    logic                loc_ready;
    logic [`COORD_W-1:0] loc_x;
    logic [`COORD_W-1:0] loc_y;
    logic                pix_valid;
    logic                pix_ready;
    logic [`COORD_W-1:0] pix_x;
    logic [`COORD_W-1:0] pix_y;
    logic [`COLOR_W-1:0] pix_color;
    logic                shader_empty;
    logic                writer_empty;

    draw_control u_control (
        .clk          (clk),
        .reset        (reset),
        .go           (go),
        .job_done     (job_done),
        .shader_empty (shader_empty),
        .writer_empty (writer_empty),
        .job          (job),
        .job_start    (job_start),
        .busy         (busy)
    );

    raster_scanner u_scanner (
        .clk       (clk),
        .reset     (reset),
        .job       (job),
        .job_start (job_start),
        .loc_ready (loc_ready),
        .loc_valid (loc_valid),
        .loc_x     (loc_x),
        .loc_y     (loc_y),
        .job_done  (job_done)
    );

    // Scanner, shader and writer each hold at most one pixel.
    pixel_shader u_shader (
        .clk          (clk),
        .reset        (reset),
        .job          (job),
        .loc_valid    (loc_valid),
        .loc_x        (loc_x),
        .loc_y        (loc_y),
        .score        (score),
        .lives        (lives),
        .frog_x       (frog_x),
        .frog_y       (frog_y),
        .pix_ready    (pix_ready),
        .loc_ready    (loc_ready),
        .pix_valid    (pix_valid),
        .pix_x        (pix_x),
        .pix_y        (pix_y),
        .pix_color    (pix_color),
        .shader_empty (shader_empty)
    );

    wb_pixel_writer u_writer (
        .clk          (clk),
        .reset        (reset),
        .pix_valid    (pix_valid),
        .pix_x        (pix_x),
        .pix_y        (pix_y),
        .pix_color    (pix_color),
        .wb_ack       (wb_ack),
        .pix_ready    (pix_ready),
        .writer_empty (writer_empty),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat       (wb_dat)
    );

endmodule

//--- bench/frog_draw_properties.sv
`include "frog_consts.svh"

module frog_draw_properties (
    input logic                clk,
    input logic                reset,
    input logic                busy,
    input logic                wb_cyc,
    input logic                wb_stb,
    input logic                wb_ack,
    input logic [`ADDR_W-1:0]  wb_adr,
    input logic [`COLOR_W-1:0] wb_dat
);

    timeunit 1ns;
    timeprecision 100ps;

    a_stb_in_cyc: assert property (@(posedge clk) disable iff (reset) wb_stb |-> wb_cyc)
        else $error("wb_stb high outside a bus cycle");

    // Slave may stall as long as it likes.
    a_hold: assert property (@(posedge clk) disable iff (reset)
        wb_stb && !wb_ack |=> $stable(wb_adr) && $stable(wb_dat))
        else $error("wb_adr or wb_dat changed while waiting for ack");

    a_adr_range: assert property (@(posedge clk) disable iff (reset)
        wb_stb |-> wb_adr < `ADDR_W'(`SCREEN_W * `SCREEN_H))
        else $error("wb_adr beyond the last pixel");

    a_idle_bus: assert property (@(posedge clk) disable iff (reset) !busy |-> !wb_cyc)
        else $error("bus cycle open while not busy");

endmodule

bind frog_draw_top frog_draw_properties u_properties (
    .clk    (clk),
    .reset  (reset),
    .busy   (busy),
    .wb_cyc (wb_cyc),
    .wb_stb (wb_stb),
    .wb_ack (wb_ack),
    .wb_adr (wb_adr),
    .wb_dat (wb_dat)
);

//--- bench/tb_frog_draw.sv
`include "frog_consts.svh"

module tb_frog_draw;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int FB_SIZE = `SCREEN_W * `SCREEN_H;
    localparam int FRAME_PIXELS = FB_SIZE + 2 * `DIGIT_W * `DIGIT_H +
                                  2 * `OBJ_W * `OBJ_H + `FROG_W * `FROG_H;

    logic                clk;
    logic                reset;
    logic                go;
    logic [3:0]          score;
    logic [3:0]          lives;
    logic [`COORD_W-1:0] frog_x;
    logic [`COORD_W-1:0] frog_y;
    logic                busy;
    logic                wb_cyc;
    logic                wb_stb;
    logic                wb_we;
    logic [`ADDR_W-1:0]  wb_adr;
    logic [`COLOR_W-1:0] wb_dat;
    logic                wb_ack;

    logic [`COLOR_W-1:0] fb [0:FB_SIZE-1];
    int                  case_vals [$];
    int                  num_cases;
    int                  write_count;
    int                  frames;
    int                  checks;
    int                  errors;
    int                  cycles;
    int                  cycle_limit;
    int                  ack_delay;
    logic                ack_armed;
    integer              seed = 32'hfc32;

    frog_draw_top u_dut (
        .clk    (clk),
        .reset  (reset),
        .go     (go),
        .score  (score),
        .lives  (lives),
        .frog_x (frog_x),
        .frog_y (frog_y),
        .busy   (busy),
        .wb_cyc (wb_cyc),
        .wb_stb (wb_stb),
        .wb_we  (wb_we),
        .wb_adr (wb_adr),
        .wb_dat (wb_dat),
        .wb_ack (wb_ack)
    );

    always #2 clk = ~clk;

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0t ns: %s: got %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    task automatic end_run();
        $display("checks: %0d, errors: %0d, frames: %0d", checks, errors, frames);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    // Frame-buffer slave with a random wait of 0 to 3 cycles before each ack.
    always @(posedge clk) begin
        if (reset) begin
            wb_ack    <= 1'b0;
            ack_armed = 1'b0;
        end else if (wb_ack) begin
            wb_ack    <= 1'b0;
            ack_armed = 1'b0;
            if (wb_stb) begin
                check(32'(wb_we), 1, "wb_we on acked write");
                if (wb_adr < FB_SIZE) begin
                    fb[wb_adr]  <= wb_dat;
                    write_count <= write_count + 1;
                end else begin
                    $display("write outside the frame buffer at %0t ns", $time);
                    errors++;
                end
            end
        end else if (wb_stb) begin
            if (!ack_armed) begin
                ack_delay = $unsigned($random(seed)) % 4;
                ack_armed = 1'b1;
            end
            if (ack_delay == 0) begin
                wb_ack <= 1'b1;
            end else begin
                ack_delay = ack_delay - 1;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("timeout: frame never finished");
            errors++;
            end_run();
        end
    end

    task automatic load_cases();
        int    fd;
        int    n;
        int    v [16];
        string line;
        fd = $fopen("bench/frog_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open bench/frog_cases.txt");
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 0 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                                v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7],
                                v[8], v[9], v[10], v[11], v[12], v[13], v[14], v[15]);
                    if (n == 16) begin
                        foreach (v[i]) begin
                            case_vals.push_back(v[i]);
                        end
                    end else if (n > 0) begin
                        $display("malformed line in case file: %s", line);
                        errors++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic start_frame(input int c);
        @(posedge clk);
        score       <= 4'(case_vals[c * 16]);
        lives       <= 4'(case_vals[c * 16 + 1]);
        frog_x      <= `COORD_W'(case_vals[c * 16 + 2]);
        frog_y      <= `COORD_W'(case_vals[c * 16 + 3]);
        go          <= 1'b1;
        write_count <= 0;
        @(posedge clk);
        go <= 1'b0;
        @(posedge clk);
        check(32'(busy), 1, "busy after go");
    endtask

    // Reset in the middle of a frame.
    task automatic abort_frame();
        while (write_count < 2000) @(posedge clk);
        reset <= 1'b1;
        @(posedge clk);
        @(posedge clk);
        check(32'(busy), 0, "busy after mid-frame reset");
        check(32'(wb_cyc), 0, "wb_cyc after mid-frame reset");
        reset <= 1'b0;
    endtask

    task automatic finish_frame();
        // A go while busy must not start another frame.
        while (write_count < 500) @(posedge clk);
        go <= 1'b1;
        @(posedge clk);
        go <= 1'b0;
        while (busy) @(posedge clk);
        check(32'(write_count), FRAME_PIXELS, "pixel writes in frame");
        check(32'(wb_cyc), 0, "wb_cyc after busy fell");
        frames++;
    endtask

    task automatic check_probes(input int c);
        int px;
        int py;
        for (int p = 0; p < 4; p++) begin
            px = case_vals[c * 16 + 4 + p * 3];
            py = case_vals[c * 16 + 5 + p * 3];
            check(32'(fb[py * `SCREEN_W + px]), case_vals[c * 16 + 6 + p * 3],
                  $sformatf("case %0d pixel (%0d,%0d)", c, px, py));
        end
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        go          = 1'b0;
        score       = '0;
        lives       = '0;
        frog_x      = '0;
        frog_y      = '0;
        wb_ack      = 1'b0;
        cycles      = 0;
        cycle_limit = 0;
        load_cases();
        num_cases   = case_vals.size() / 16;
        cycle_limit = num_cases * 90000 * 5;
        if (num_cases == 0) begin
            $display("no usable cases in bench/frog_cases.txt");
            errors++;
        end else begin
            repeat (5) @(posedge clk);
            reset <= 1'b0;
            for (int c = 0; c < num_cases; c++) begin
                if (c == 0) begin
                    start_frame(c);
                    abort_frame();
                end
                start_frame(c);
                finish_frame();
                check_probes(c);
            end
        end
        end_run();
    end

endmodule

//--- bench/frog_cases.txt
# score lives frog_x frog_y, then four probes as x y colour, all decimal
# colours: 0 black, 1 water, 2 grass, 3 frog, 6 log, 7 ink
1 3 144 216   10 10 2   303 17 7   50 100 6   150 220 3
8 0 300 230   300 230 3   288 216 3   301 15 0   303 31 7
12 5 0 0   303 18 0   301 15 0   301 28 7   200 170 6
9 7 100 40   250 100 1   110 50 3   20 80 6   306 23 0
4 2 60 90   70 100 3   30 85 6   115 119 6   5 239 2
0 15 319 239   10 39 2   10 40 1   10 199 1   10 200 2

//--- compile.f
+incdir+rtl
rtl/frog_pkg.sv
rtl/draw_control.sv
rtl/raster_scanner.sv
rtl/pixel_shader.sv
rtl/wb_pixel_writer.sv
rtl/frog_draw_top.sv
bench/frog_draw_properties.sv
bench/tb_frog_draw.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
TOP       = tb_frog_draw
FILELIST  = compile.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test failed" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
